// ==== filelist.f ====
video_pkg.sv
xga_timing.sv
vram_arbiter.sv
zbt_sram.sv
vram_display.sv
frame_display_top.sv
tb_frame_display.sv

// ==== frame_cases.txt ====
# W word_addr(hex) word(hex, 36 bit)   word_addr = y*512 + x/2
# C x(dec) y(dec) pixel(hex, 18 bit)   even x upper half, odd x lower half
W 00000 FC0000FC0
W 001FF 000FD5555
W 5FE00 AAAA80001
W 5FFFF 48D17ABCD
W 00200 3C3C30303
W 25902 444460820
W 30140 FFFFC0000
W 12345 111111111
W 12345 282805050
C 0 0 3F000
C 1 0 00FC0
C 1022 0 0003F
C 1023 0 15555
C 0 767 2AAAA
C 1 767 00001
C 1022 767 12345
C 1023 767 3ABCD
C 0 1 0F0F0
C 517 300 20820
C 640 384 3FFFF
C 650 145 0A0A0
C 651 145 05050

// ==== frame_display_top.sv ====
////////////////////////////////////////
// XGA frame buffer display, top level
// timing, memory arbiter, ZBT model and read path
// external writer posts single cycle strobes into the buffer
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module frame_display_top (
   input  wire                           clk,
   input  wire                           rst_n,
   input  wire                           wr_strobe,
   input  wire  [video_pkg::ADDR_W-1:0]  wr_addr,
   input  wire  [video_pkg::WORD_W-1:0]  wr_data,
   output logic [7:0]                    vga_red,
   output logic [7:0]                    vga_green,
   output logic [7:0]                    vga_blue,
   output logic                          vga_hsync,
   output logic                          vga_vsync,
   output logic                          vga_blank_n
);

   // timing bus
   logic [video_pkg::HCOUNT_W-1:0] hcount;
   logic [video_pkg::VCOUNT_W-1:0] vcount;
   logic                           hsync;
   logic                           vsync;
   logic                           blank;

   // memory port
   logic                           mem_we;
   logic [video_pkg::ADDR_W-1:0]   mem_addr;
   logic [video_pkg::WORD_W-1:0]   mem_wdata;
   logic [video_pkg::WORD_W-1:0]   mem_rdata;
   logic [video_pkg::ADDR_W-1:0]   rd_addr;

   xga_timing u_timing (
      .clk    (clk),
      .rst_n  (rst_n),
      .hcount (hcount),
      .vcount (vcount),
      .hsync  (hsync),
      .vsync  (vsync),
      .blank  (blank)
   );

   vram_arbiter u_arbiter (
      .clk       (clk),
      .rst_n     (rst_n),
      .hcount    (hcount),
      .rd_addr   (rd_addr),
      .wr_strobe (wr_strobe),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata)
   );

   zbt_sram u_sram (
      .clk   (clk),
      .we    (mem_we),
      .addr  (mem_addr),
      .wdata (mem_wdata),
      .rdata (mem_rdata)
   );

   vram_display u_display (
      .clk         (clk),
      .rst_n       (rst_n),
      .hcount      (hcount),
      .vcount      (vcount),
      .hsync       (hsync),
      .vsync       (vsync),
      .blank       (blank),
      .mem_rdata   (mem_rdata),
      .rd_addr     (rd_addr),
      .vga_red     (vga_red),
      .vga_green   (vga_green),
      .vga_blue    (vga_blue),
      .vga_hsync   (vga_hsync),
      .vga_vsync   (vga_vsync),
      .vga_blank_n (vga_blank_n)
   );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# compile the frame display testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module tb_frame_display -f filelist.f -o tb_frame_display
./obj_dir/tb_frame_display

// ==== tb_frame_display.sv ====
////////////////////////////////////////
// self checking testbench for the XGA frame buffer display
// posts the writes from frame_cases.txt, then follows the beam
// on the VGA outputs and checks geometry and probed pixels
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_frame_display;

   // XGA 60 Hz geometry, in clocks and lines
   localparam int     RESET_CYCLES    = 16;
   localparam int     ACTIVE_PIXELS   = 1024;
   localparam int     ACTIVE_LINES    = 768;
   localparam longint LINE_CYCLES     = 1344;
   localparam longint HSYNC_CYCLES    = 136;
   localparam longint VSYNC_CYCLES    = 6 * LINE_CYCLES;
   localparam longint FRAME_CYCLES    = 806 * LINE_CYCLES;
   localparam longint WATCHDOG_CYCLES = RESET_CYCLES + 3 * FRAME_CYCLES;
   localparam int     FILLER_WRITES   = 8;
   localparam logic [31:0] SEED       = 32'hd4e4_8150;

   logic                          clk;
   logic                          rst_n;
   logic                          wr_strobe;
   logic [video_pkg::ADDR_W-1:0]  wr_addr;
   logic [video_pkg::WORD_W-1:0]  wr_data;
   logic [7:0]                    vga_red;
   logic [7:0]                    vga_green;
   logic [7:0]                    vga_blue;
   logic                          vga_hsync;
   logic                          vga_vsync;
   logic                          vga_blank_n;

   // cases file contents
   logic [video_pkg::ADDR_W-1:0]  w_addr_q [$];
   logic [video_pkg::WORD_W-1:0]  w_data_q [$];
   logic [video_pkg::WORD_W-1:0]  word_model [int];
   logic [17:0]                   probe_pix [int];
   bit                            probe_word [int];

   // beam tracking state
   longint      cycle = 0;
   longint      last_hs_fall = 0;
   longint      last_vs_fall = 0;
   bit          hs_fall_seen = 1'b0;
   bit          vs_fall_seen = 1'b0;
   bit          in_reset_seen = 1'b0;
   bit          tracking = 1'b0;
   logic        prev_hs = 1'b1;
   logic        prev_vs = 1'b1;
   logic        prev_bn = 1'b0;
   int          line_y = -1;
   int          pix_x = 0;
   int          probes_hit = 0;
   int          full_frames = 0;
   logic [17:0] exp_pix;

   frame_display_top dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .wr_strobe   (wr_strobe),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .vga_red     (vga_red),
      .vga_green   (vga_green),
      .vga_blue    (vga_blue),
      .vga_hsync   (vga_hsync),
      .vga_vsync   (vga_vsync),
      .vga_blank_n (vga_blank_n)
   );

   // 4 ns pixel clock
   always #2 clk = ~clk;

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////

   task automatic check_equal(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("ERR @ %0t: %s, got %0h expected %0h", $time, what, got, exp);
         $display("** FAIL **");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic check_reset_outputs(input string when);
      check_equal({"vga_hsync ", when}, 64'(vga_hsync), 64'd1);
      check_equal({"vga_vsync ", when}, 64'(vga_vsync), 64'd1);
      check_equal({"vga_blank_n ", when}, 64'(vga_blank_n), 64'd0);
   endtask

   // one strobe, then two idle cycles so the hold drains
   task automatic post_write(input logic [video_pkg::ADDR_W-1:0] addr,
                             input logic [video_pkg::WORD_W-1:0] data);
      wr_strobe <= 1'b1;
      wr_addr   <= addr;
      wr_data   <= data;
      @(posedge clk);
      wr_strobe <= 1'b0;
      repeat (2) @(posedge clk);
   endtask

   task automatic load_cases();
      int                           fd;
      int                           n;
      int                           x;
      int                           y;
      string                        line;
      logic [video_pkg::ADDR_W-1:0] a;
      logic [video_pkg::WORD_W-1:0] d;
      logic [17:0]                  p;
      fd = $fopen("frame_cases.txt", "r");
      if (fd == 0) begin
         $display("could not open frame_cases.txt for reading");
         $display("** FAIL **");
         $fatal(1, "missing cases file");
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line[0] == "W") begin
               n = $sscanf(line, "W %h %h", a, d);
               check_equal("fields on W line", 64'(n), 64'd2);
               w_addr_q.push_back(a);
               w_data_q.push_back(d);
               // later writes to the same word replace earlier ones
               word_model[int'(a)] = d;
            end else if (line[0] == "C") begin
               n = $sscanf(line, "C %d %d %h", x, y, p);
               check_equal("fields on C line", 64'(n), 64'd3);
               probe_pix[y * ACTIVE_PIXELS + x] = p;
               probe_word[y * 512 + x / 2] = 1'b1;
            end
         end
         $fclose(fd);
         // probe values must follow from the words written, even x upper half
         foreach (probe_pix[k]) begin
            x = k % ACTIVE_PIXELS;
            y = k / ACTIVE_PIXELS;
            n = y * 512 + x / 2;
            check_equal("probed word written", 64'(word_model.exists(n)), 64'd1);
            d = word_model[n];
            check_equal($sformatf("cases file pixel (%0d,%0d)", x, y), 64'(probe_pix[k]),
                        64'((x % 2 == 0) ? d[35:18] : d[17:0]));
         end
      end
   endtask

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////

   initial begin
      logic [31:0]                  rnd;
      logic [31:0]                  rnd_hi;
      logic [video_pkg::ADDR_W-1:0] fill_addr;
      clk       = 1'b0;
      rst_n     = 1'b0;
      wr_strobe = 1'b0;
      wr_addr   = '0;
      wr_data   = '0;
      rnd = $urandom(SEED);
      load_cases();
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      repeat (2) @(posedge clk);
      for (int i = 0; i < w_addr_q.size(); i++) begin
         post_write(w_addr_q[i], w_data_q[i]);
      end
      // filler traffic, kept off every probed word
      for (int i = 0; i < FILLER_WRITES; i++) begin
         do begin
            rnd       = $urandom;
            fill_addr = rnd[video_pkg::ADDR_W-1:0];
         end while (probe_word.exists(int'(fill_addr)));
         rnd_hi = $urandom;
         rnd    = $urandom;
         post_write(fill_addr, {rnd_hi[3:0], rnd});
      end
   end

   // whole run fits in three frames
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired before two full frames were displayed");
      $display("** FAIL **");
      $fatal(1, "timeout");
   end

   ////////////////////////////////////////
   // beam monitor, sampled on the falling edge
   ////////////////////////////////////////

   always @(negedge clk) begin
      if (!rst_n) begin
         check_reset_outputs("during reset");
         in_reset_seen = 1'b1;
      end else begin
         if (in_reset_seen) begin
            check_reset_outputs("right after reset");
            in_reset_seen = 1'b0;
         end
         cycle++;
         // hsync period and pulse width
         if (prev_hs && !vga_hsync) begin
            if (hs_fall_seen) begin
               check_equal("hsync period", 64'(cycle - last_hs_fall), 64'(LINE_CYCLES));
            end
            hs_fall_seen = 1'b1;
            last_hs_fall = cycle;
         end
         if (!prev_hs && vga_hsync && hs_fall_seen) begin
            check_equal("hsync width", 64'(cycle - last_hs_fall), 64'(HSYNC_CYCLES));
         end
         // vsync period
         if (prev_vs && !vga_vsync) begin
            if (vs_fall_seen) begin
               check_equal("frame period", 64'(cycle - last_vs_fall), 64'(FRAME_CYCLES));
            end
            vs_fall_seen = 1'b1;
            last_vs_fall = cycle;
         end
         // vsync rise closes a frame, the next active line is y = 0
         if (!prev_vs && vga_vsync && vs_fall_seen) begin
            check_equal("vsync width", 64'(cycle - last_vs_fall), 64'(VSYNC_CYCLES));
            if (tracking) begin
               check_equal("active lines per frame", 64'(line_y + 1), 64'(ACTIVE_LINES));
               check_equal("probes seen per frame", 64'(probes_hit), 64'(probe_pix.num()));
               full_frames++;
            end
            tracking   = 1'b1;
            line_y     = -1;
            probes_hit = 0;
         end
         if (!prev_bn && vga_blank_n) begin
            line_y++;
            pix_x = 0;
         end
         if (vga_blank_n) begin
            if (tracking && probe_pix.exists(line_y * ACTIVE_PIXELS + pix_x)) begin
               exp_pix = probe_pix[line_y * ACTIVE_PIXELS + pix_x];
               // 6 bit field on top, two zero bits below
               check_equal($sformatf("red at (%0d,%0d)", pix_x, line_y),
                           64'(vga_red), 64'({exp_pix[17:12], 2'b00}));
               check_equal($sformatf("green at (%0d,%0d)", pix_x, line_y),
                           64'(vga_green), 64'({exp_pix[11:6], 2'b00}));
               check_equal($sformatf("blue at (%0d,%0d)", pix_x, line_y),
                           64'(vga_blue), 64'({exp_pix[5:0], 2'b00}));
               probes_hit++;
            end
            pix_x++;
         end
         if (prev_bn && !vga_blank_n && tracking) begin
            check_equal("active pixels per line", 64'(pix_x), 64'(ACTIVE_PIXELS));
         end
         prev_hs = vga_hsync;
         prev_vs = vga_vsync;
         prev_bn = vga_blank_n;
      end
      if (full_frames == 2) begin
         $display("** PASS **");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== video_pkg.sv ====
////////////////////////////////////////
// shared constants for the XGA frame buffer display
// timing thresholds, bus widths and the memory slot encoding
// referenced by scoped name from every block in the design
////////////////////////////////////////

`default_nettype none

package video_pkg;

   // counter widths
   parameter int HCOUNT_W = 11;
   parameter int VCOUNT_W = 10;

   // horizontal timing, in pixel clocks
   parameter logic [HCOUNT_W-1:0] H_ACTIVE   = 11'd1024;
   parameter logic [HCOUNT_W-1:0] H_SYNC_ON  = 11'd1048;
   parameter logic [HCOUNT_W-1:0] H_SYNC_OFF = 11'd1184;
   parameter logic [HCOUNT_W-1:0] H_TOTAL    = 11'd1344;

   // vertical timing, in lines
   parameter logic [VCOUNT_W-1:0] V_ACTIVE   = 10'd768;
   parameter logic [VCOUNT_W-1:0] V_SYNC_ON  = 10'd777;
   parameter logic [VCOUNT_W-1:0] V_SYNC_OFF = 10'd783;
   parameter logic [VCOUNT_W-1:0] V_TOTAL    = 10'd806;

   // frame buffer word holds two pixels side by side
   parameter int ADDR_W  = 19;
   parameter int WORD_W  = 36;
   parameter int PIXEL_W = 18;

   // read address runs this many clocks ahead of the beam
   parameter logic [HCOUNT_W-1:0] FORECAST_LEAD = 11'd8;

   // ZBT pipeline depth
   parameter int READ_LATENCY = 2;

   // memory slot, picked by bit 0 of the pixel counter
   typedef enum logic {
      SLOT_READ  = 1'b0,
      SLOT_WRITE = 1'b1
   } slot_e;

endpackage

`default_nettype wire

// ==== vram_arbiter.sv ====
////////////////////////////////////////
// frame buffer port sharing
// parks one posted write until the next odd pixel slot,
// even slots carry the display read address
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module vram_arbiter (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire  [video_pkg::HCOUNT_W-1:0] hcount,
   input  wire  [video_pkg::ADDR_W-1:0]   rd_addr,
   input  wire                            wr_strobe,
   input  wire  [video_pkg::ADDR_W-1:0]   wr_addr,
   input  wire  [video_pkg::WORD_W-1:0]   wr_data,
   output logic                           mem_we,
   output logic [video_pkg::ADDR_W-1:0]   mem_addr,
   output logic [video_pkg::WORD_W-1:0]   mem_wdata
);

   video_pkg::slot_e             slot;
   logic                         hold_valid;
   logic [video_pkg::ADDR_W-1:0] hold_addr;
   logic [video_pkg::WORD_W-1:0] hold_data;
   logic                         issue;

   // slot follows pixel parity
   assign slot  = video_pkg::slot_e'(hcount[0]);
   assign issue = hold_valid && (slot == video_pkg::SLOT_WRITE);

   ////////////////////////////////////////
   // one entry write hold
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hold_valid <= 1'b0;
      end else if (wr_strobe) begin
         hold_valid <= 1'b1;
      end else if (issue) begin
         hold_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_strobe) begin
         hold_addr <= wr_addr;
         hold_data <= wr_data;
      end
   end

   ////////////////////////////////////////
   // memory port mux
   ////////////////////////////////////////

   // the ZBT registers these on its own input stage
   assign mem_we    = issue;
   assign mem_addr  = issue ? hold_addr : rd_addr;
   assign mem_wdata = hold_data;

   // writer keeps strobes far enough apart that the hold has drained
   a_strobe_spacing: assert property (
      @(posedge clk) disable iff (!rst_n)
      wr_strobe |-> !hold_valid
   );

endmodule

`default_nettype wire

// ==== vram_display.sv ====
////////////////////////////////////////
// frame buffer read path and VGA output stage
// issues read addresses eight clocks ahead of the beam,
// realigns returned words to pixel pairs and drives the DAC
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module vram_display (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire  [video_pkg::HCOUNT_W-1:0] hcount,
   input  wire  [video_pkg::VCOUNT_W-1:0] vcount,
   input  wire                            hsync,
   input  wire                            vsync,
   input  wire                            blank,
   input  wire  [video_pkg::WORD_W-1:0]   mem_rdata,
   output logic [video_pkg::ADDR_W-1:0]   rd_addr,
   output logic [7:0]                     vga_red,
   output logic [7:0]                     vga_green,
   output logic [7:0]                     vga_blue,
   output logic                           vga_hsync,
   output logic                           vga_vsync,
   output logic                           vga_blank_n
);

   localparam int CHAN_W = video_pkg::PIXEL_W / 3;
   localparam int PAD_W  = 8 - CHAN_W;
   localparam logic [video_pkg::HCOUNT_W-1:0] WRAP_AT =
      video_pkg::H_TOTAL - video_pkg::FORECAST_LEAD;

   logic                           wrap_f;
   logic [video_pkg::HCOUNT_W-1:0] hcount_f;
   logic [video_pkg::VCOUNT_W-1:0] vcount_f;
   logic [video_pkg::WORD_W-1:0]   latch_word;
   logic [video_pkg::WORD_W-1:0]   lead_word;
   logic [video_pkg::WORD_W-1:0]   disp_word;
   logic [video_pkg::PIXEL_W-1:0]  pixel;

   ////////////////////////////////////////
   // address forecast
   ////////////////////////////////////////

   // position the beam reaches FORECAST_LEAD clocks from now,
   // late in the line this is already on the next line or frame
   assign wrap_f   = (hcount >= WRAP_AT);
   assign hcount_f = wrap_f ? hcount - WRAP_AT : hcount + video_pkg::FORECAST_LEAD;
   assign vcount_f = !wrap_f ? vcount :
                     (vcount == video_pkg::V_TOTAL - 1'b1) ? '0 : vcount + 1'b1;

   // 512 words per line, one word per pixel pair
   assign rd_addr = {vcount_f, hcount_f[video_pkg::HCOUNT_W-2:1]};

   ////////////////////////////////////////
   // word realignment
   ////////////////////////////////////////

   // read sent on even pixel h comes back during h+3 (odd)
   // two more pair stages bring it to h+8, the pair it belongs to
   always_ff @(posedge clk) begin
      if (hcount[0]) begin
         latch_word <= mem_rdata;
         lead_word  <= latch_word;
         // pair boundary, disp_word now covers the next even/odd pixels
         disp_word  <= lead_word;
      end
   end

   // even pixel in the upper half, odd in the lower
   assign pixel = hcount[0] ? disp_word[video_pkg::PIXEL_W-1:0]
                            : disp_word[video_pkg::WORD_W-1:video_pkg::PIXEL_W];

   ////////////////////////////////////////
   // VGA output registers
   ////////////////////////////////////////

   // colour and sync each pass one register, so they stay aligned
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vga_red     <= '0;
         vga_green   <= '0;
         vga_blue    <= '0;
         vga_hsync   <= 1'b1;
         vga_vsync   <= 1'b1;
         vga_blank_n <= 1'b0;
      end else begin
         // 6 bit channels on the top of each 8 bit DAC input
         vga_red     <= blank ? '0 : {pixel[3*CHAN_W-1 -: CHAN_W], {PAD_W{1'b0}}};
         vga_green   <= blank ? '0 : {pixel[2*CHAN_W-1 -: CHAN_W], {PAD_W{1'b0}}};
         vga_blue    <= blank ? '0 : {pixel[CHAN_W-1   -: CHAN_W], {PAD_W{1'b0}}};
         vga_hsync   <= hsync;
         vga_vsync   <= vsync;
         vga_blank_n <= !blank;
      end
   end

endmodule

`default_nettype wire

// ==== xga_timing.sv ====
////////////////////////////////////////
// XGA 1024x768 at 60 Hz timing generator
// free running pixel and line counters with active low
// sync and a combined blanking flag, all registered together
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module xga_timing (
   input  wire                           clk,
   input  wire                           rst_n,
   output logic [video_pkg::HCOUNT_W-1:0] hcount,
   output logic [video_pkg::VCOUNT_W-1:0] vcount,
   output logic                          hsync,
   output logic                          vsync,
   output logic                          blank
);

   logic                          line_end;
   logic                          frame_end;
   logic [video_pkg::HCOUNT_W-1:0] hcount_nxt;
   logic [video_pkg::VCOUNT_W-1:0] vcount_nxt;

   ////////////////////////////////////////
   // next position
   ////////////////////////////////////////

   assign line_end  = (hcount == video_pkg::H_TOTAL - 1'b1);
   assign frame_end = line_end && (vcount == video_pkg::V_TOTAL - 1'b1);

   assign hcount_nxt = line_end ? '0 : hcount + 1'b1;

   // line counter only steps on the last pixel of a line
   assign vcount_nxt = frame_end ? '0 :
                       line_end  ? vcount + 1'b1 : vcount;

   ////////////////////////////////////////
   // counters and flags
   ////////////////////////////////////////

   // flags are decoded from the next position so they
   // line up with the counter values on the same cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         // park on the last pixel of the frame, first step lands on 0,0
         hcount <= video_pkg::H_TOTAL - 1'b1;
         vcount <= video_pkg::V_TOTAL - 1'b1;
         hsync  <= 1'b1;
         vsync  <= 1'b1;
         blank  <= 1'b1;
      end else begin
         hcount <= hcount_nxt;
         vcount <= vcount_nxt;
         // active low sync pulses
         hsync  <= !((hcount_nxt >= video_pkg::H_SYNC_ON) &&
                     (hcount_nxt <  video_pkg::H_SYNC_OFF));
         vsync  <= !((vcount_nxt >= video_pkg::V_SYNC_ON) &&
                     (vcount_nxt <  video_pkg::V_SYNC_OFF));
         // blank outside the visible 1024x768 window
         blank  <= (hcount_nxt >= video_pkg::H_ACTIVE) ||
                   (vcount_nxt >= video_pkg::V_ACTIVE);
      end
   end

   // pixel counter never leaves the line
   a_hcount_range: assert property (
      @(posedge clk) disable iff (!rst_n)
      hcount < video_pkg::H_TOTAL
   );

endmodule

`default_nettype wire

// ==== zbt_sram.sv ====
////////////////////////////////////////
// behavioural model of the pipelined ZBT frame buffer
// address, enable and data are sampled, carried down the pipe
// and the final stage both commits writes and returns read data
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module zbt_sram (
   input  wire                           clk,
   input  wire                           we,
   input  wire  [video_pkg::ADDR_W-1:0]  addr,
   input  wire  [video_pkg::WORD_W-1:0]  wdata,
   output logic [video_pkg::WORD_W-1:0]  rdata
);

   // stages ahead of the array access, the array stage is the last one
   localparam int PIPE_D = video_pkg::READ_LATENCY;
   localparam int LAST   = PIPE_D - 1;
   localparam int DEPTH  = 1 << video_pkg::ADDR_W;

   logic [video_pkg::WORD_W-1:0] mem [DEPTH];

   logic [video_pkg::ADDR_W-1:0] addr_pipe [PIPE_D];
   logic [video_pkg::WORD_W-1:0] data_pipe [PIPE_D];
   logic                         we_pipe   [PIPE_D];

   ////////////////////////////////////////
   // input pipeline
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      addr_pipe[0] <= addr;
      data_pipe[0] <= wdata;
      we_pipe[0]   <= we;
      for (int i = 1; i < PIPE_D; i++) begin
         addr_pipe[i] <= addr_pipe[i-1];
         data_pipe[i] <= data_pipe[i-1];
         we_pipe[i]   <= we_pipe[i-1];
      end
   end

   ////////////////////////////////////////
   // array stage
   ////////////////////////////////////////

   // read returns the old word when the same stage writes it,
   // so a read issued one cycle after a write sees the new data
   always_ff @(posedge clk) begin
      if (we_pipe[LAST]) begin
         mem[addr_pipe[LAST]] <= data_pipe[LAST];
      end
      rdata <= mem[addr_pipe[LAST]];
   end

endmodule

`default_nettype wire
